/* src/rv_control_config.svh */
/*
 * RV32I control unit configuration.
 * Widths, ALU operation codes and load/store byte-lane masks.
 */
`ifndef RV_CONTROL_CONFIG_SVH
`define RV_CONTROL_CONFIG_SVH

`define XLEN        32
`define ALU_OP_W    4
`define LDST_MASK_W 4

`define MASK_BYTE   4'b0001
`define MASK_HALF   4'b0011
`define MASK_WORD   4'b1111

`define ALU_OP_ADD  4'b0000
`define ALU_OP_SUB  4'b1000
`define ALU_OP_SRL  4'b0001
`define ALU_OP_SLL  4'b0011
`define ALU_OP_SRA  4'b0111
`define ALU_OP_SLT  4'b0011
`define ALU_OP_SLTU 4'b0111
`define ALU_OP_XOR  4'b0100
`define ALU_OP_OR   4'b0110
`define ALU_OP_AND  4'b0111

`define ALU_OP_BEQ  4'b0000
`define ALU_OP_BNE  4'b0001
`define ALU_OP_BGE  4'b0010
`define ALU_OP_BLT  4'b0011
`define ALU_OP_BGEU 4'b0110
`define ALU_OP_BLTU 4'b0111

`endif

/* src/rv_isa_pkg.sv */
/*
 * RV32I instruction encoding: field layout, major opcodes
 * and the funct3 encodings of each instruction class.
 */
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // R-type view, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000, // ADD/SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101, // SRL/SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } store_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

endpackage

/* src/rv_ctrl_pkg.sv */
/*
 * Control output types of the decode unit: operand and
 * write-back selects, the control structs and redirect states.
 */
`include "rv_control_config.svh"

package rv_ctrl_pkg;

    typedef enum logic [1:0] {
        ARITH   = 2'b00,
        LOGIC   = 2'b01,
        SHIFT   = 2'b10,
        COMPARE = 2'b11
    } alu_unit_e;

    typedef enum logic [1:0] {
        REG  = 2'b00,
        PC   = 2'b01,
        ZERO = 2'b10
    } operand_a_e;

    typedef enum logic [1:0] {
        ALU       = 2'b00,
        MEM       = 2'b01,
        PC_PLUS_4 = 2'b10
    } wb_src_e;

    typedef struct packed {
        logic                  imm_select;   // 1 selects the immediate as operand B
        operand_a_e            operand_a;
        logic                  cmp_operands; // Branch compare of rs1/rs2
        alu_unit_e             unit;
        logic [`ALU_OP_W-1:0]  op;
    } alu_ctrl_t;

    typedef struct packed {
        logic [`LDST_MASK_W-1:0] mask;
        logic                    is_unsigned;
        logic                    st_en;
    } mem_ctrl_t;

    typedef struct packed {
        logic    rf_w_en;
        wb_src_e rf_w_select;
    } wb_ctrl_t;

    typedef struct packed {
        logic branch;
        logic jump;
    } flow_ctrl_t;

    typedef enum logic {
        RUN    = 1'b0,
        SQUASH = 1'b1
    } redirect_state_e;

endpackage

/* src/instr_decoder.sv */
/*
 * Instruction decoder. Turns one RV32I instruction into ALU,
 * memory, write-back and flow controls in the same cycle.
 */
`include "rv_control_config.svh"

module instr_decoder
(
    input  rv_isa_pkg::instr_t      instr,
    output rv_ctrl_pkg::alu_ctrl_t  alu_ctrl,
    output rv_ctrl_pkg::mem_ctrl_t  mem_ctrl,
    output rv_ctrl_pkg::wb_ctrl_t   wb_ctrl,
    output rv_ctrl_pkg::flow_ctrl_t flow_ctrl
);

    always_comb
    begin
        // Defaults decode as a no-op
        alu_ctrl.imm_select   = 1'b1;
        alu_ctrl.operand_a    = rv_ctrl_pkg::REG;
        alu_ctrl.cmp_operands = 1'b0;
        alu_ctrl.unit         = rv_ctrl_pkg::ARITH;
        alu_ctrl.op           = `ALU_OP_ADD;
        mem_ctrl              = '0;
        wb_ctrl.rf_w_en       = 1'b0;
        wb_ctrl.rf_w_select   = rv_ctrl_pkg::ALU;
        flow_ctrl             = '0;

        case (rv_isa_pkg::opcode_e'(instr.opcode))
            rv_isa_pkg::OP, rv_isa_pkg::OP_IMM:
            begin
                wb_ctrl.rf_w_en     = 1'b1;
                alu_ctrl.imm_select = (instr.opcode != rv_isa_pkg::OP);
                case (rv_isa_pkg::alu_f3_e'(instr.funct3))
                    rv_isa_pkg::F3_ADD:
                    begin
                        // SUB exists only in register form
                        if (instr.opcode == rv_isa_pkg::OP && instr.funct7[5])
                            alu_ctrl.op = `ALU_OP_SUB;
                    end
                    rv_isa_pkg::F3_SLL:
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::SHIFT;
                        alu_ctrl.op   = `ALU_OP_SLL;
                    end
                    rv_isa_pkg::F3_SLT:
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::COMPARE;
                        alu_ctrl.op   = `ALU_OP_SLT;
                    end
                    rv_isa_pkg::F3_SLTU:
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::COMPARE;
                        alu_ctrl.op   = `ALU_OP_SLTU;
                    end
                    rv_isa_pkg::F3_XOR:
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::LOGIC;
                        alu_ctrl.op   = `ALU_OP_XOR;
                    end
                    rv_isa_pkg::F3_OR:
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::LOGIC;
                        alu_ctrl.op   = `ALU_OP_OR;
                    end
                    rv_isa_pkg::F3_AND:
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::LOGIC;
                        alu_ctrl.op   = `ALU_OP_AND;
                    end
                    default: // SRL/SRA, SRLI/SRAI
                    begin
                        alu_ctrl.unit = rv_ctrl_pkg::SHIFT;
                        alu_ctrl.op   = instr.funct7[5] ? `ALU_OP_SRA : `ALU_OP_SRL;
                    end
                endcase
            end
            rv_isa_pkg::LOAD:
            begin
                case (rv_isa_pkg::load_f3_e'(instr.funct3))
                    rv_isa_pkg::F3_LB:  mem_ctrl.mask = `MASK_BYTE;
                    rv_isa_pkg::F3_LH:  mem_ctrl.mask = `MASK_HALF;
                    rv_isa_pkg::F3_LW:  mem_ctrl.mask = `MASK_WORD;
                    rv_isa_pkg::F3_LBU:
                    begin
                        mem_ctrl.mask        = `MASK_BYTE;
                        mem_ctrl.is_unsigned = 1'b1;
                    end
                    rv_isa_pkg::F3_LHU:
                    begin
                        mem_ctrl.mask        = `MASK_HALF;
                        mem_ctrl.is_unsigned = 1'b1;
                    end
                    default: ;
                endcase
                if (mem_ctrl.mask != '0) // Known width only
                begin
                    wb_ctrl.rf_w_en     = 1'b1;
                    wb_ctrl.rf_w_select = rv_ctrl_pkg::MEM;
                end
            end
            rv_isa_pkg::STORE:
            begin
                case (rv_isa_pkg::store_f3_e'(instr.funct3))
                    rv_isa_pkg::F3_SB: mem_ctrl.mask = `MASK_BYTE;
                    rv_isa_pkg::F3_SH: mem_ctrl.mask = `MASK_HALF;
                    rv_isa_pkg::F3_SW: mem_ctrl.mask = `MASK_WORD;
                    default: ;
                endcase
                mem_ctrl.st_en = (mem_ctrl.mask != '0);
            end
            rv_isa_pkg::BRANCH:
            begin
                flow_ctrl.branch = 1'b1;
                case (rv_isa_pkg::branch_f3_e'(instr.funct3))
                    rv_isa_pkg::F3_BEQ:  alu_ctrl.op = `ALU_OP_BEQ;
                    rv_isa_pkg::F3_BNE:  alu_ctrl.op = `ALU_OP_BNE;
                    rv_isa_pkg::F3_BLT:  alu_ctrl.op = `ALU_OP_BLT;
                    rv_isa_pkg::F3_BGE:  alu_ctrl.op = `ALU_OP_BGE;
                    rv_isa_pkg::F3_BLTU: alu_ctrl.op = `ALU_OP_BLTU;
                    rv_isa_pkg::F3_BGEU: alu_ctrl.op = `ALU_OP_BGEU;
                    default:             flow_ctrl.branch = 1'b0;
                endcase
                if (flow_ctrl.branch)
                begin
                    alu_ctrl.operand_a    = rv_ctrl_pkg::PC; // Target is PC + imm
                    alu_ctrl.cmp_operands = 1'b1;
                end
            end
            rv_isa_pkg::JAL:
            begin
                flow_ctrl.jump      = 1'b1;
                alu_ctrl.operand_a  = rv_ctrl_pkg::PC;
                wb_ctrl.rf_w_en     = 1'b1;
                wb_ctrl.rf_w_select = rv_ctrl_pkg::PC_PLUS_4; // Link address
            end
            rv_isa_pkg::JALR:
            begin
                flow_ctrl.jump      = 1'b1;
                wb_ctrl.rf_w_en     = 1'b1;
                wb_ctrl.rf_w_select = rv_ctrl_pkg::PC_PLUS_4;
            end
            rv_isa_pkg::LUI:
            begin
                alu_ctrl.operand_a = rv_ctrl_pkg::ZERO; // 0 + upper imm
                wb_ctrl.rf_w_en    = 1'b1;
            end
            rv_isa_pkg::AUIPC:
            begin
                alu_ctrl.operand_a = rv_ctrl_pkg::PC;
                wb_ctrl.rf_w_en    = 1'b1;
            end
            default: ; // FENCE, SYSTEM and illegal opcodes
        endcase
    end

endmodule

/* src/redirect_fsm.sv */
/*
 * Redirect control. Holds the decode-stage branch/jump flags and
 * raises make_nop once per taken redirect, then skips one cycle.
 */
module redirect_fsm
(
    input  logic                    clk,
    input  logic                    rst,
    input  rv_ctrl_pkg::flow_ctrl_t flow_ctrl,
    input  logic                    branch_true,
    output logic                    make_nop
);

    rv_ctrl_pkg::flow_ctrl_t      flow_id;     // Flags of the instruction in decode
    rv_ctrl_pkg::redirect_state_e state;
    rv_ctrl_pkg::redirect_state_e state_next;

    assign make_nop = (state == rv_ctrl_pkg::RUN) &&
                      (flow_id.jump || (flow_id.branch && branch_true));

    always_comb
    begin
        case (state)
            rv_ctrl_pkg::RUN:    state_next = make_nop ? rv_ctrl_pkg::SQUASH : rv_ctrl_pkg::RUN;
            rv_ctrl_pkg::SQUASH: state_next = rv_ctrl_pkg::RUN; // Flushed slot done
            default:             state_next = rv_ctrl_pkg::RUN;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flow_id <= '0;
            state   <= rv_ctrl_pkg::RUN;
        end
        else
        begin
            flow_id <= flow_ctrl;
            state   <= state_next;
        end
    end

endmodule

/* src/rv_control.sv */
/*
 * RV32I decode control unit. Combinational instruction decode
 * plus the squash logic for taken branches and jumps.
 */
module rv_control
(
    input  logic                    clk,
    input  logic                    rst,
    input  rv_isa_pkg::instr_t      instr,
    input  logic                    branch_true,
    output rv_ctrl_pkg::alu_ctrl_t  alu_ctrl,
    output rv_ctrl_pkg::mem_ctrl_t  mem_ctrl,
    output rv_ctrl_pkg::wb_ctrl_t   wb_ctrl,
    output rv_ctrl_pkg::flow_ctrl_t flow_ctrl,
    output logic                    make_nop
);

    rv_ctrl_pkg::flow_ctrl_t flow_dec; // Also feeds the redirect logic

    assign flow_ctrl = flow_dec;

    instr_decoder decoder0
    (
        .instr     (instr),
        .alu_ctrl  (alu_ctrl),
        .mem_ctrl  (mem_ctrl),
        .wb_ctrl   (wb_ctrl),
        .flow_ctrl (flow_dec)
    );

    redirect_fsm redirect0
    (
        .clk         (clk),
        .rst         (rst),
        .flow_ctrl   (flow_dec),
        .branch_true (branch_true),
        .make_nop    (make_nop)
    );

endmodule

/* tb/tb_ref_model.svh */
/*
 * Reference decode and random instruction source for the
 * control unit testbench.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] lcg_state = 32'h14abfb04;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [6:0] opcode_at(input int k);
    case (k)
        0:       return rv_isa_pkg::OP;
        1:       return rv_isa_pkg::OP_IMM;
        2:       return rv_isa_pkg::LOAD;
        3:       return rv_isa_pkg::STORE;
        4:       return rv_isa_pkg::BRANCH;
        5:       return rv_isa_pkg::JAL;
        6:       return rv_isa_pkg::JALR;
        7:       return rv_isa_pkg::LUI;
        8:       return rv_isa_pkg::AUIPC;
        9:       return 7'b0001111; // FENCE
        10:      return 7'b1110011; // SYSTEM
        default: return 7'b1111111;
    endcase
endfunction

function automatic rv_isa_pkg::instr_t rand_instr(input bit no_op);
    rv_isa_pkg::instr_t i;
    int                 k;
    i = lcg_next();
    if (no_op)
        k = 9 + int'((lcg_next() >> 8) % 32'd3);
    else
        k = int'((lcg_next() >> 8) % 32'd9);
    i.opcode = opcode_at(k);
    return i;
endfunction

// Byte lanes per funct3, unsigned widths exist for loads only
function automatic logic [`LDST_MASK_W-1:0] size_mask(input logic [2:0] f3, input bit is_load);
    case (f3)
        3'b000:  return `MASK_BYTE;
        3'b001:  return `MASK_HALF;
        3'b010:  return `MASK_WORD;
        3'b100:  return is_load ? `MASK_BYTE : 4'b0000;
        3'b101:  return is_load ? `MASK_HALF : 4'b0000;
        default: return 4'b0000;
    endcase
endfunction

task automatic decode_ref(input rv_isa_pkg::instr_t i,
                          output rv_ctrl_pkg::alu_ctrl_t a,
                          output rv_ctrl_pkg::mem_ctrl_t m,
                          output rv_ctrl_pkg::wb_ctrl_t w,
                          output rv_ctrl_pkg::flow_ctrl_t f);
    a = '0; // REG, ARITH, ADD
    a.imm_select = 1'b1;
    m = '0;
    w = '0;
    f = '0;
    case (i.opcode)
        rv_isa_pkg::OP, rv_isa_pkg::OP_IMM:
        begin
            w.rf_w_en    = 1'b1;
            a.imm_select = (i.opcode == rv_isa_pkg::OP_IMM);
            case (i.funct3)
                3'b000:  a.op = (i.opcode == rv_isa_pkg::OP && i.funct7[5]) ? `ALU_OP_SUB
                                                                             : `ALU_OP_ADD;
                3'b001:  a.op = `ALU_OP_SLL;
                3'b010:  a.op = `ALU_OP_SLT;
                3'b011:  a.op = `ALU_OP_SLTU;
                3'b100:  a.op = `ALU_OP_XOR;
                3'b101:  a.op = i.funct7[5] ? `ALU_OP_SRA : `ALU_OP_SRL;
                3'b110:  a.op = `ALU_OP_OR;
                default: a.op = `ALU_OP_AND;
            endcase
            case (i.funct3)
                3'b000:         a.unit = rv_ctrl_pkg::ARITH;
                3'b001, 3'b101: a.unit = rv_ctrl_pkg::SHIFT;
                3'b010, 3'b011: a.unit = rv_ctrl_pkg::COMPARE;
                default:        a.unit = rv_ctrl_pkg::LOGIC;
            endcase
        end
        rv_isa_pkg::LOAD:
        begin
            m.mask        = size_mask(i.funct3, 1'b1);
            m.is_unsigned = i.funct3[2] && (m.mask != '0);
            if (m.mask != '0)
            begin
                w.rf_w_en     = 1'b1;
                w.rf_w_select = rv_ctrl_pkg::MEM;
            end
        end
        rv_isa_pkg::STORE:
        begin
            m.mask  = size_mask(i.funct3, 1'b0);
            m.st_en = |m.mask;
        end
        rv_isa_pkg::BRANCH:
        begin
            if (i.funct3[2:1] != 2'b01) // 010 and 011 are not branches
            begin
                f.branch       = 1'b1;
                a.operand_a    = rv_ctrl_pkg::PC;
                a.cmp_operands = 1'b1;
                case (i.funct3)
                    3'b000:  a.op = `ALU_OP_BEQ;
                    3'b001:  a.op = `ALU_OP_BNE;
                    3'b100:  a.op = `ALU_OP_BLT;
                    3'b101:  a.op = `ALU_OP_BGE;
                    3'b110:  a.op = `ALU_OP_BLTU;
                    default: a.op = `ALU_OP_BGEU;
                endcase
            end
        end
        rv_isa_pkg::JAL, rv_isa_pkg::JALR:
        begin
            f.jump        = 1'b1;
            w.rf_w_en     = 1'b1;
            w.rf_w_select = rv_ctrl_pkg::PC_PLUS_4;
            if (i.opcode == rv_isa_pkg::JAL)
                a.operand_a = rv_ctrl_pkg::PC;
        end
        rv_isa_pkg::LUI:
        begin
            a.operand_a = rv_ctrl_pkg::ZERO;
            w.rf_w_en   = 1'b1;
        end
        rv_isa_pkg::AUIPC:
        begin
            a.operand_a = rv_ctrl_pkg::PC;
            w.rf_w_en   = 1'b1;
        end
        default: ;
    endcase
endtask

`endif

/* tb/tb_rv_control.sv */
/*
 * Testbench for the RV32I decode control unit. Random and directed
 * instructions, checked by assertions against a reference decode.
 */
`include "rv_control_config.svh"

module tb_rv_control;

    localparam int RANDOM_COUNT = 400;
    localparam int NOOP_COUNT   = 60;
    localparam int WAIT_LIMIT   = 8;
    localparam int RUN_LIMIT    = 2000;

    logic                    clk;
    logic                    rst;
    rv_isa_pkg::instr_t      instr;
    logic                    branch_true;
    rv_ctrl_pkg::alu_ctrl_t  alu_ctrl;
    rv_ctrl_pkg::mem_ctrl_t  mem_ctrl;
    rv_ctrl_pkg::wb_ctrl_t   wb_ctrl;
    rv_ctrl_pkg::flow_ctrl_t flow_ctrl;
    logic                    make_nop;

    rv_ctrl_pkg::alu_ctrl_t  exp_alu;
    rv_ctrl_pkg::mem_ctrl_t  exp_mem;
    rv_ctrl_pkg::wb_ctrl_t   exp_wb;
    rv_ctrl_pkg::flow_ctrl_t exp_flow;
    rv_ctrl_pkg::flow_ctrl_t pend;        // Expected decode-stage flags
    logic                    squash_prev; // A squash happened last cycle
    logic                    exp_nop;
    logic                    noop_phase;

    `include "tb_ref_model.svh"

    rv_control dut0
    (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .branch_true (branch_true),
        .alu_ctrl    (alu_ctrl),
        .mem_ctrl    (mem_ctrl),
        .wb_ctrl     (wb_ctrl),
        .flow_ctrl   (flow_ctrl),
        .make_nop    (make_nop)
    );

    always #50 clk = ~clk;

    assign exp_nop = !squash_prev && (pend.jump || (pend.branch && branch_true));

    always @(posedge clk)
    begin
        if (rst)
        begin
            pend        <= '0;
            squash_prev <= 1'b0;
        end
        else
        begin
            pend        <= exp_flow;
            squash_prev <= exp_nop;
        end
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        fail_stop("decode output differs from the reference");
    endtask

    alu_check: assert property (@(negedge clk) alu_ctrl == exp_alu)
        else report_mismatch("alu_ctrl", 32'(exp_alu), 32'(alu_ctrl));
    mem_check: assert property (@(negedge clk) mem_ctrl == exp_mem)
        else report_mismatch("mem_ctrl", 32'(exp_mem), 32'(mem_ctrl));
    wb_check: assert property (@(negedge clk) wb_ctrl == exp_wb)
        else report_mismatch("wb_ctrl", 32'(exp_wb), 32'(wb_ctrl));
    flow_check: assert property (@(negedge clk) flow_ctrl == exp_flow)
        else report_mismatch("flow_ctrl", 32'(exp_flow), 32'(flow_ctrl));
    noop_check: assert property (@(negedge clk)
        noop_phase |-> (!wb_ctrl.rf_w_en && !mem_ctrl.st_en && flow_ctrl == '0))
        else fail_stop("no-op opcode decoded to a write, store, branch or jump");
    reset_check: assert property (@(negedge clk) (rst || $fell(rst)) |-> !make_nop)
        else fail_stop("make_nop high during or right after reset");
    squash_check: assert property (@(negedge clk) disable iff (rst) make_nop == exp_nop)
        else report_mismatch("make_nop", 32'(exp_nop), 32'(make_nop));
    repeat_check: assert property (@(negedge clk) disable iff (rst) $past(make_nop) |-> !make_nop)
        else fail_stop("make_nop high in two cycles in a row");

    // New instruction shortly after the rising edge
    task automatic drive(input rv_isa_pkg::instr_t i, input logic taken, input logic noop);
        @(posedge clk);
        #10;
        instr       = i;
        branch_true = taken;
        noop_phase  = noop;
        decode_ref(i, exp_alu, exp_mem, exp_wb, exp_flow);
    endtask

    task automatic wait_for_squash();
        int n;
        n = 0;
        while (!make_nop && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!make_nop)
            fail_stop("timeout waiting for make_nop");
    endtask

    initial
    begin : watchdog
        int cycles;
        for (cycles = 0; cycles < RUN_LIMIT; cycles++)
            @(posedge clk);
        fail_stop("timeout, the run did not finish");
    end

    initial
    begin
        rv_isa_pkg::instr_t bubble;
        rv_isa_pkg::instr_t br;
        rv_isa_pkg::instr_t jmp;
        logic [31:0]        r;
        int                 k;
        clk         = 1'b0;
        rst         = 1'b1;
        branch_true = 1'b0;
        noop_phase  = 1'b0;
        bubble        = '0;
        bubble.opcode = rv_isa_pkg::OP_IMM; // ADDI x0, x0, 0
        br            = '0;
        br.opcode     = rv_isa_pkg::BRANCH; // BEQ
        jmp           = '0;
        jmp.opcode    = rv_isa_pkg::JAL;
        instr         = jmp; // Jump in decode that reset has to clear
        decode_ref(instr, exp_alu, exp_mem, exp_wb, exp_flow);
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;

        for (k = 0; k < RANDOM_COUNT; k++)
        begin
            r = lcg_next();
            drive(rand_instr(1'b0), r[16], 1'b0);
        end
        for (k = 0; k < NOOP_COUNT; k++)
        begin
            r = lcg_next();
            drive(rand_instr(1'b1), r[16], 1'b1);
        end

        drive(bubble, 1'b0, 1'b0);
        drive(bubble, 1'b0, 1'b0);
        drive(br, 1'b0, 1'b0);     // Taken branch
        drive(bubble, 1'b1, 1'b0);
        wait_for_squash();
        drive(bubble, 1'b0, 1'b0);
        drive(br, 1'b0, 1'b0);     // Not taken
        drive(bubble, 1'b0, 1'b0);
        drive(bubble, 1'b0, 1'b0);
        drive(jmp, 1'b0, 1'b0);    // Jump followed by a jump
        drive(jmp, 1'b0, 1'b0);
        wait_for_squash();
        drive(bubble, 1'b0, 1'b0);
        drive(jmp, 1'b0, 1'b0);    // Back in RUN
        drive(bubble, 1'b0, 1'b0);
        wait_for_squash();
        drive(bubble, 1'b0, 1'b0);
        @(negedge clk);
        @(negedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* rv_control.f */
+incdir+src
+incdir+tb
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/instr_decoder.sv
src/redirect_fsm.sv
src/rv_control.sv
tb/tb_rv_control.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rv_control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_control.f --top-module tb_rv_control -Mdir obj_dir

# A fatal stop exits nonzero, the log decides the result
./obj_dir/Vtb_rv_control | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi
echo "Simulation passed"
